/* hw/issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// ============================================================
// Core sizes
// ============================================================

// Architectural registers and their index width
`define NUM_REGS 16
`define REG_IDX_W 4

// Data path and instruction word
`define DATA_W 16
`define INSTR_W 16

// Scheduler window
`define RS_DEPTH 4
// Age counter width without the wrap bit
`define AGE_W 3

`endif

/* hw/isa_pkg.sv */
`include "issue_defines.svh"

package isa_pkg;

  localparam int OPCODE_W = 3;
  localparam int IMM_W    = 8;
  // Shift amount comes from the low bits of source 1
  localparam int SHAMT_W  = 4;

  // Field positions in the instruction word
  localparam int OP_MSB   = `INSTR_W - 1;
  localparam int OP_LSB   = 13;
  localparam int DEST_MSB = 12;
  localparam int DEST_LSB = 9;
  localparam int SRC0_MSB = 8;
  localparam int SRC0_LSB = 5;
  localparam int SRC1_MSB = 4;
  localparam int SRC1_LSB = 1;
  // Load immediate overlays both source fields
  localparam int IMM_MSB  = 8;
  localparam int IMM_LSB  = 1;

  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5,
    OP_SHR = 3'd6,
    OP_LI  = 3'd7
  } isa_opcode_e;

endpackage

/* hw/sched_pkg.sv */
`include "issue_defines.svh"

package sched_pkg;

  // Dispatch order tag, wrap bit flips each time idx rolls over
  typedef struct packed {
    logic              wrap;
    logic [`AGE_W-1:0] idx;
  } age_tag_t;

  typedef struct packed {
    logic                  valid;
    isa_pkg::isa_opcode_e  opcode;
    logic [`REG_IDX_W-1:0] dest;
    logic [`REG_IDX_W-1:0] src0;
    logic                  src0_valid;
    logic                  src0_ready;
    logic [`REG_IDX_W-1:0] src1;
    logic                  src1_valid;
    logic                  src1_ready;
    logic [`DATA_W-1:0]    imm;
    age_tag_t              age;
  } rs_entry_t;

  // DEC_STALL means an instruction sits in the decode register
  typedef enum logic {
    DEC_IDLE  = 1'b0,
    DEC_STALL = 1'b1
  } dec_state_e;

endpackage

/* hw/instr_decode.sv */
`include "issue_defines.svh"

module instr_decode
  import isa_pkg::*, sched_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  input  logic [`INSTR_W-1:0]   instr_i,
  input  logic                  rs_has_free_i,
  input  logic                  wb_valid_i,
  input  logic [`REG_IDX_W-1:0] wb_dest_i,
  output logic                  in_ready_o,
  output logic                  disp_valid_o,
  output isa_opcode_e           disp_op_o,
  output logic [`REG_IDX_W-1:0] disp_dest_o,
  output logic [`REG_IDX_W-1:0] disp_src0_o,
  output logic                  disp_src0_valid_o,
  output logic                  disp_src0_ready_o,
  output logic [`REG_IDX_W-1:0] disp_src1_o,
  output logic                  disp_src1_valid_o,
  output logic                  disp_src1_ready_o,
  output logic [`DATA_W-1:0]    disp_imm_o,
  output age_tag_t              disp_age_o
);

  dec_state_e            state_q, state_d;
  logic                  live_q;
  logic [`NUM_REGS-1:0]  busy_q, busy_d;
  // Registers still to be read by a waiting station entry
  logic [`NUM_REGS-1:0]  rpend_q, rpend_d;
  age_tag_t              age_q;

  isa_opcode_e           f_op;
  logic [`REG_IDX_W-1:0] f_dest, f_src0, f_src1;
  logic                  f_src_valid, f_src0_ready, f_src1_ready, f_waits;
  logic                  accept, dispatch;

  // ============================================================
  // Field extraction
  // ============================================================
  assign f_op   = isa_opcode_e'(instr_i[OP_MSB:OP_LSB]);
  assign f_dest = instr_i[DEST_MSB:DEST_LSB];
  assign f_src0 = instr_i[SRC0_MSB:SRC0_LSB];
  assign f_src1 = instr_i[SRC1_MSB:SRC1_LSB];
  assign f_src_valid = (f_op != OP_LI);

  // A result broadcast this cycle already counts as available
  assign f_src0_ready = !busy_q[f_src0] || (wb_valid_i && wb_dest_i == f_src0);
  assign f_src1_ready = !busy_q[f_src1] || (wb_valid_i && wb_dest_i == f_src1);
  assign f_waits = f_src_valid && !(f_src0_ready && f_src1_ready);

  // ============================================================
  // Handshake and state
  // ============================================================
  // Destination must be free of pending writes and pending reads
  assign in_ready_o = live_q && !flush_i && rs_has_free_i &&
                      !busy_q[f_dest] && !rpend_q[f_dest];
  assign accept     = in_valid_i && in_ready_o;
  assign disp_valid_o = (state_q == DEC_STALL);
  assign dispatch   = disp_valid_o && rs_has_free_i;
  assign disp_age_o = age_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_IDLE:  if (accept) state_d = DEC_STALL;
      DEC_STALL: if (dispatch && !accept) state_d = DEC_IDLE;
      default:   state_d = DEC_IDLE;
    endcase
  end

  always_comb begin
    busy_d = busy_q;
    if (wb_valid_i) busy_d[wb_dest_i] = 1'b0;
    if (accept) busy_d[f_dest] = 1'b1;
    // With nothing in flight no entry can still be waiting to read
    rpend_d = (busy_q == '0) ? '0 : rpend_q;
    if (accept && f_waits) begin
      rpend_d[f_src0] = 1'b1;
      rpend_d[f_src1] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DEC_IDLE;
      live_q  <= 1'b0;
      busy_q  <= '0;
      rpend_q <= '0;
      age_q   <= '0;
    end else if (flush_i) begin
      state_q <= DEC_IDLE;
      live_q  <= 1'b0;
      busy_q  <= '0;
      rpend_q <= '0;
    end else begin
      state_q <= state_d;
      live_q  <= 1'b1;
      busy_q  <= busy_d;
      rpend_q <= rpend_d;
      if (dispatch) age_q <= age_tag_t'({age_q.wrap, age_q.idx} + 1'b1);
    end
  end

  // Held instruction, ready bits keep tracking broadcasts
  always_ff @(posedge clk) begin
    if (accept) begin
      disp_op_o         <= f_op;
      disp_dest_o       <= f_dest;
      disp_src0_o       <= f_src0;
      disp_src1_o       <= f_src1;
      disp_src0_valid_o <= f_src_valid;
      disp_src1_valid_o <= f_src_valid;
      disp_src0_ready_o <= f_src0_ready;
      disp_src1_ready_o <= f_src1_ready;
      disp_imm_o        <= {{(`DATA_W-IMM_W){1'b0}}, instr_i[IMM_MSB:IMM_LSB]};
    end else if (wb_valid_i) begin
      if (wb_dest_i == disp_src0_o) disp_src0_ready_o <= 1'b1;
      if (wb_dest_i == disp_src1_o) disp_src1_ready_o <= 1'b1;
    end
  end

  // Full station keeps the same instruction parked in decode
  a_hold_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    disp_valid_o && !rs_has_free_i && !flush_i |=>
      disp_valid_o && $stable(disp_dest_o) && $stable(disp_age_o));

endmodule

/* hw/reservation_station.sv */
`include "issue_defines.svh"

module reservation_station
  import isa_pkg::*, sched_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  disp_valid_i,
  input  isa_opcode_e           disp_op_i,
  input  logic [`REG_IDX_W-1:0] disp_dest_i,
  input  logic [`REG_IDX_W-1:0] disp_src0_i,
  input  logic                  disp_src0_valid_i,
  input  logic                  disp_src0_ready_i,
  input  logic [`REG_IDX_W-1:0] disp_src1_i,
  input  logic                  disp_src1_valid_i,
  input  logic                  disp_src1_ready_i,
  input  logic [`DATA_W-1:0]    disp_imm_i,
  input  age_tag_t              disp_age_i,
  input  logic                  wb_valid_i,
  input  logic [`REG_IDX_W-1:0] wb_dest_i,
  output logic                  rs_has_free_o,
  output logic                  issue_valid_o,
  output isa_opcode_e           issue_op_o,
  output logic [`REG_IDX_W-1:0] issue_dest_o,
  output logic [`REG_IDX_W-1:0] issue_src0_o,
  output logic [`REG_IDX_W-1:0] issue_src1_o,
  output logic [`DATA_W-1:0]    issue_imm_o
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  rs_entry_t [`RS_DEPTH-1:0] mem_q, mem_d;
  rs_entry_t                 new_entry;
  logic [`RS_DEPTH-1:0]      free;
  logic [`RS_DEPTH-1:0]      ready;
  logic [IDX_W-1:0]          wr_idx;
  logic [IDX_W-1:0]          sel_idx;
  logic                      older_ready;

  // Wrap bits differ once the counter has rolled past the other tag
  function automatic logic is_older(age_tag_t a, age_tag_t b);
    if (a.wrap == b.wrap) begin
      return a.idx < b.idx;
    end
    return a.idx > b.idx;
  endfunction

  // ============================================================
  // Slot status and write position
  // ============================================================
  always_comb begin
    wr_idx = '0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      free[i]  = !mem_q[i].valid;
      ready[i] = mem_q[i].valid &&
                 (mem_q[i].src0_ready || !mem_q[i].src0_valid) &&
                 (mem_q[i].src1_ready || !mem_q[i].src1_valid);
      if (free[i]) wr_idx = IDX_W'(i);
    end
  end

  assign rs_has_free_o = |free;

  // ============================================================
  // Oldest ready select
  // ============================================================
  always_comb begin
    issue_valid_o = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (ready[i] && (!issue_valid_o || is_older(mem_q[i].age, mem_q[sel_idx].age))) begin
        issue_valid_o = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  // Any ready entry that beats the selected one
  always_comb begin
    older_ready = 1'b0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (ready[i] && is_older(mem_q[i].age, mem_q[sel_idx].age)) older_ready = 1'b1;
    end
  end

  assign issue_op_o   = mem_q[sel_idx].opcode;
  assign issue_dest_o = mem_q[sel_idx].dest;
  assign issue_src0_o = mem_q[sel_idx].src0;
  assign issue_src1_o = mem_q[sel_idx].src1;
  assign issue_imm_o  = mem_q[sel_idx].imm;

  // ============================================================
  // Wakeup, write and release
  // ============================================================
  always_comb begin
    new_entry.valid      = 1'b1;
    new_entry.opcode     = disp_op_i;
    new_entry.dest       = disp_dest_i;
    new_entry.src0       = disp_src0_i;
    new_entry.src0_valid = disp_src0_valid_i;
    new_entry.src1       = disp_src1_i;
    new_entry.src1_valid = disp_src1_valid_i;
    new_entry.imm        = disp_imm_i;
    new_entry.age        = disp_age_i;
    // Incoming entry must not miss a broadcast in its write cycle
    new_entry.src0_ready = disp_src0_ready_i || (wb_valid_i && wb_dest_i == disp_src0_i);
    new_entry.src1_ready = disp_src1_ready_i || (wb_valid_i && wb_dest_i == disp_src1_i);

    mem_d = mem_q;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (wb_valid_i && mem_q[i].valid) begin
        if (mem_q[i].src0 == wb_dest_i) mem_d[i].src0_ready = 1'b1;
        if (mem_q[i].src1 == wb_dest_i) mem_d[i].src1_ready = 1'b1;
      end
    end
    if (issue_valid_o) mem_d[sel_idx].valid = 1'b0;
    if (disp_valid_i && rs_has_free_o) mem_d[wr_idx] = new_entry;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_q <= '0;
    end else if (flush_i) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  // The issued entry is the oldest of all ready entries
  a_issue_oldest: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid_o |-> !older_ready);

endmodule

/* hw/alu_execute.sv */
`include "issue_defines.svh"

module alu_execute
  import isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  issue_valid_i,
  input  isa_opcode_e           issue_op_i,
  input  logic [`REG_IDX_W-1:0] issue_dest_i,
  input  logic [`REG_IDX_W-1:0] issue_src0_i,
  input  logic [`REG_IDX_W-1:0] issue_src1_i,
  input  logic [`DATA_W-1:0]    issue_imm_i,
  input  logic [`DATA_W-1:0]    rd_data0_i,
  input  logic [`DATA_W-1:0]    rd_data1_i,
  output logic [`REG_IDX_W-1:0] rd_addr0_o,
  output logic [`REG_IDX_W-1:0] rd_addr1_o,
  output logic                  ex_valid_o,
  output logic [`REG_IDX_W-1:0] ex_dest_o,
  output logic [`DATA_W-1:0]    ex_data_o
);

  logic               valid_q;
  isa_opcode_e        op_q;
  logic [`DATA_W-1:0] a_q, b_q, imm_q;

  // Operands are read in the issue cycle
  assign rd_addr0_o = issue_src0_i;
  assign rd_addr1_o = issue_src1_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i && !flush_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i) begin
      op_q      <= issue_op_i;
      ex_dest_o <= issue_dest_i;
      a_q       <= rd_data0_i;
      b_q       <= rd_data1_i;
      imm_q     <= issue_imm_i;
    end
  end

  // Result held during a flush is dropped before it reaches the register file
  assign ex_valid_o = valid_q && !flush_i;

  always_comb begin
    case (op_q)
      OP_ADD:  ex_data_o = a_q + b_q;
      OP_SUB:  ex_data_o = a_q - b_q;
      OP_AND:  ex_data_o = a_q & b_q;
      OP_OR:   ex_data_o = a_q | b_q;
      OP_XOR:  ex_data_o = a_q ^ b_q;
      OP_SHL:  ex_data_o = a_q << b_q[SHAMT_W-1:0];
      OP_SHR:  ex_data_o = a_q >> b_q[SHAMT_W-1:0];
      OP_LI:   ex_data_o = imm_q;
      default: ex_data_o = '0;
    endcase
  end

  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o == ($past(issue_valid_i && !flush_i) && !flush_i));

endmodule

/* hw/result_regfile.sv */
`include "issue_defines.svh"

module result_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`REG_IDX_W-1:0] rd_addr0_i,
  input  logic [`REG_IDX_W-1:0] rd_addr1_i,
  input  logic                  ex_valid_i,
  input  logic [`REG_IDX_W-1:0] ex_dest_i,
  input  logic [`DATA_W-1:0]    ex_data_i,
  output logic [`DATA_W-1:0]    rd_data0_o,
  output logic [`DATA_W-1:0]    rd_data1_o,
  output logic                  wb_valid_o,
  output logic [`REG_IDX_W-1:0] wb_dest_o,
  output logic [`DATA_W-1:0]    wb_data_o
);

  logic [`DATA_W-1:0] regs_q [`NUM_REGS];

  // Forward a value that is being written this cycle
  assign rd_data0_o = (ex_valid_i && ex_dest_i == rd_addr0_i) ? ex_data_i
                                                              : regs_q[rd_addr0_i];
  assign rd_data1_o = (ex_valid_i && ex_dest_i == rd_addr1_i) ? ex_data_i
                                                              : regs_q[rd_addr1_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
      wb_valid_o <= 1'b0;
    end else begin
      if (ex_valid_i) regs_q[ex_dest_i] <= ex_data_i;
      wb_valid_o <= ex_valid_i;
    end
  end

  // Broadcast payload
  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      wb_dest_o <= ex_dest_i;
      wb_data_o <= ex_data_i;
    end
  end

endmodule

/* hw/issue_core_top.sv */
`include "issue_defines.svh"

module issue_core_top
  import isa_pkg::*, sched_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  input  logic [`INSTR_W-1:0]   instr_i,
  output logic                  in_ready_o,
  output logic                  wb_valid_o,
  output logic [`REG_IDX_W-1:0] wb_dest_o,
  output logic [`DATA_W-1:0]    wb_data_o
);

  // Decode to station
  logic                  disp_valid, rs_has_free;
  isa_opcode_e           disp_op;
  logic [`REG_IDX_W-1:0] disp_dest, disp_src0, disp_src1;
  logic                  disp_src0_valid, disp_src0_ready;
  logic                  disp_src1_valid, disp_src1_ready;
  logic [`DATA_W-1:0]    disp_imm;
  age_tag_t              disp_age;

  // Station to execute
  logic                  issue_valid;
  isa_opcode_e           issue_op;
  logic [`REG_IDX_W-1:0] issue_dest, issue_src0, issue_src1;
  logic [`DATA_W-1:0]    issue_imm;

  // Execute to result
  logic [`REG_IDX_W-1:0] rd_addr0, rd_addr1, ex_dest;
  logic [`DATA_W-1:0]    rd_data0, rd_data1, ex_data;
  logic                  ex_valid;

  instr_decode u_decode (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (flush_i),
    .in_valid_i        (in_valid_i),
    .instr_i           (instr_i),
    .rs_has_free_i     (rs_has_free),
    .wb_valid_i        (wb_valid_o),
    .wb_dest_i         (wb_dest_o),
    .in_ready_o        (in_ready_o),
    .disp_valid_o      (disp_valid),
    .disp_op_o         (disp_op),
    .disp_dest_o       (disp_dest),
    .disp_src0_o       (disp_src0),
    .disp_src0_valid_o (disp_src0_valid),
    .disp_src0_ready_o (disp_src0_ready),
    .disp_src1_o       (disp_src1),
    .disp_src1_valid_o (disp_src1_valid),
    .disp_src1_ready_o (disp_src1_ready),
    .disp_imm_o        (disp_imm),
    .disp_age_o        (disp_age)
  );

  reservation_station u_rs (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (flush_i),
    .disp_valid_i      (disp_valid),
    .disp_op_i         (disp_op),
    .disp_dest_i       (disp_dest),
    .disp_src0_i       (disp_src0),
    .disp_src0_valid_i (disp_src0_valid),
    .disp_src0_ready_i (disp_src0_ready),
    .disp_src1_i       (disp_src1),
    .disp_src1_valid_i (disp_src1_valid),
    .disp_src1_ready_i (disp_src1_ready),
    .disp_imm_i        (disp_imm),
    .disp_age_i        (disp_age),
    .wb_valid_i        (wb_valid_o),
    .wb_dest_i         (wb_dest_o),
    .rs_has_free_o     (rs_has_free),
    .issue_valid_o     (issue_valid),
    .issue_op_o        (issue_op),
    .issue_dest_o      (issue_dest),
    .issue_src0_o      (issue_src0),
    .issue_src1_o      (issue_src1),
    .issue_imm_o       (issue_imm)
  );

  alu_execute u_ex (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid),
    .issue_op_i    (issue_op),
    .issue_dest_i  (issue_dest),
    .issue_src0_i  (issue_src0),
    .issue_src1_i  (issue_src1),
    .issue_imm_i   (issue_imm),
    .rd_data0_i    (rd_data0),
    .rd_data1_i    (rd_data1),
    .rd_addr0_o    (rd_addr0),
    .rd_addr1_o    (rd_addr1),
    .ex_valid_o    (ex_valid),
    .ex_dest_o     (ex_dest),
    .ex_data_o     (ex_data)
  );

  result_regfile u_rf (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_addr0_i (rd_addr0),
    .rd_addr1_i (rd_addr1),
    .ex_valid_i (ex_valid),
    .ex_dest_i  (ex_dest),
    .ex_data_i  (ex_data),
    .rd_data0_o (rd_data0),
    .rd_data1_o (rd_data1),
    .wb_valid_o (wb_valid_o),
    .wb_dest_o  (wb_dest_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

/* testbench/tb_issue_core.sv */
`include "issue_defines.svh"

module tb_issue_core;

  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT  = 400;
  localparam int QUIET_CYCLES   = 20;
  localparam int QDEPTH         = 8;

  logic                  clk;
  logic                  rst_n;
  logic                  flush_i;
  logic                  in_valid_i;
  logic [`INSTR_W-1:0]   instr_i;
  logic                  in_ready_o;
  logic                  wb_valid_o;
  logic [`REG_IDX_W-1:0] wb_dest_o;
  logic [`DATA_W-1:0]    wb_data_o;

  // Expected results per destination register, oldest at the head
  logic [`DATA_W-1:0] exp_buf [`NUM_REGS][QDEPTH];
  int                 exp_head [`NUM_REGS];
  int                 exp_cnt [`NUM_REGS];
  int                 outstanding;
  logic [`DATA_W-1:0] last_wb [`NUM_REGS];

  int              value_errors;
  int              other_errors;
  bit              aborted;
  bit              final_seen;
  logic [8*24-1:0] test_name;

  issue_core_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .in_valid_i (in_valid_i),
    .instr_i    (instr_i),
    .in_ready_o (in_ready_o),
    .wb_valid_o (wb_valid_o),
    .wb_dest_o  (wb_dest_o),
    .wb_data_o  (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ============================================================
  // Writeback monitor
  // ============================================================
  always @(negedge clk) begin
    if (rst_n && wb_valid_o) begin
      assert (exp_cnt[wb_dest_o] > 0) else begin
        $display("Writeback to r%0d with data %h was not expected during %0s",
                 wb_dest_o, wb_data_o, test_name);
        other_errors++;
      end
      if (exp_cnt[wb_dest_o] > 0) begin
        assert (wb_data_o === exp_buf[wb_dest_o][exp_head[wb_dest_o]]) else begin
          $display("ERROR %0s: r%0d expected %h actual %h", test_name, wb_dest_o,
                   exp_buf[wb_dest_o][exp_head[wb_dest_o]], wb_data_o);
          value_errors++;
        end
        exp_head[wb_dest_o] = (exp_head[wb_dest_o] + 1) % QDEPTH;
        exp_cnt[wb_dest_o]--;
        outstanding--;
      end
      last_wb[wb_dest_o] = wb_data_o;
    end
  end

  // ============================================================
  // Stimulus tasks
  // ============================================================
  task automatic expect_result(input logic [`REG_IDX_W-1:0] dest,
                               input logic [`DATA_W-1:0] value);
    int slot;
    slot = (exp_head[dest] + exp_cnt[dest]) % QDEPTH;
    exp_buf[dest][slot] = value;
    exp_cnt[dest]++;
    outstanding++;
  endtask

  // Starts and ends on a falling edge, ready sampled just before the rising edge
  task automatic send_instr(input logic [`INSTR_W-1:0] word,
                            input logic [`DATA_W-1:0] value, input bit tracked);
    int waited;
    bit taken;
    waited = 0;
    taken = 1'b0;
    in_valid_i = 1'b1;
    instr_i = word;
    while (!taken && waited < ACCEPT_TIMEOUT) begin
      #1;
      if (in_ready_o) begin
        taken = 1'b1;
        // Destination field sits in bits 12 to 9
        if (tracked) expect_result(word[12:9], value);
      end
      @(negedge clk);
      waited++;
    end
    in_valid_i = 1'b0;
    if (!taken) begin
      $display("Timeout: instruction %h was never accepted in %0s", word, test_name);
      other_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (outstanding != 0 && waited < DRAIN_TIMEOUT);
    if (outstanding != 0) begin
      $display("Timeout: %0d expected writebacks never arrived in %0s", outstanding,
               test_name);
      other_errors++;
      aborted = 1'b1;
    end
    @(negedge clk);
  endtask

  // Killed instructions have no queued result, so any writeback is flagged
  task automatic flush_pipeline();
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    repeat (QUIET_CYCLES) @(negedge clk);
  endtask

  task automatic check_final(input int fd);
    logic [`DATA_W-1:0] value;
    int                 code;
    for (int r = 0; r < `NUM_REGS; r++) begin
      code = $fscanf(fd, "%h", value);
      if (code != 1) begin
        $display("Vector file ends before the final value of r%0d", r);
        other_errors++;
      end else begin
        assert (last_wb[r] === value) else begin
          $display("ERROR %0s: r%0d expected %h actual %h", test_name, r, value, last_wb[r]);
          value_errors++;
        end
      end
    end
  endtask

  // ============================================================
  // Main flow
  // ============================================================
  initial begin : main_flow
    int                  fd;
    int                  code;
    bit                  done;
    logic [8*16-1:0]     tok;
    logic [8*128-1:0]    line;
    logic [`INSTR_W-1:0] word;
    logic [`DATA_W-1:0]  value;

    rst_n = 1'b0;
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    instr_i = '0;
    value_errors = 0;
    other_errors = 0;
    outstanding = 0;
    aborted = 1'b0;
    final_seen = 1'b0;
    done = 1'b0;
    test_name = "reset";
    for (int r = 0; r < `NUM_REGS; r++) begin
      last_wb[r] = '0;
    end

    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    fd = $fopen("testbench/issue_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file testbench/issue_vectors.txt");
      other_errors++;
      done = 1'b1;
    end

    while (!done && !aborted) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        done = 1'b1;
      end else if (tok == "#") begin
        code = $fgets(line, fd);
      end else if (tok == "TEST") begin
        code = $fscanf(fd, "%s", test_name);
      end else if (tok == "DRAIN") begin
        drain_results();
      end else if (tok == "KILL") begin
        code = $fscanf(fd, "%h", word);
        send_instr(word, '0, 1'b0);
      end else if (tok == "FLUSH") begin
        flush_pipeline();
      end else if (tok == "FINAL") begin
        test_name = "final";
        drain_results();
        check_final(fd);
        final_seen = 1'b1;
      end else begin
        code = $sscanf(tok, "%h", word);
        code = $fscanf(fd, "%h", value);
        send_instr(word, value, 1'b1);
      end
    end

    if (fd != 0) $fclose(fd);
    if (!final_seen && !aborted) begin
      $display("Vector file has no final register section");
      other_errors++;
    end

    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0 && !aborted) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/issue_vectors.txt */
# Columns: instruction word (hex) then expected writeback value (hex)
# Keywords: TEST name, DRAIN, KILL word, FLUSH, FINAL then r0 to r15 (hex)
TEST loads
E26A 0035
E418 000C
E7E0 00F0
E806 0003
DRAIN
TEST alu_ops
0E24 0041
3042 FFD7
5226 0030
7426 00F5
9626 00C5
B868 0780
DA28 0006
DRAIN
TEST dep_chain
FD02 0081
1FDC 0102
A3E8 0810
243E 070E
# r14 is reused as destination while still a pending source
9C5C 078F
A7DC 8000
D868 1000
DRAIN
TEST out_of_order
EA0A 0005
0CAA 000A
EF32 0099
50CE 0008
7224 0F1E
DRAIN
TEST backpressure
F54A 00A5
1754 014A
3974 00A5
7B68 014B
9F72 0E54
4764 010A
179A 01F0
DRAIN
TEST flush
KILL EAEE
KILL 0CAA
FLUSH
EA24 0012
0CAA 0024
DRAIN
FINAL
0000 0810 070E 010A 0003 0012 0024 0099
0008 0F1E 00A5 01F0 00A5 014B 078F 0E54

/* project.f */
+incdir+hw
hw/isa_pkg.sv
hw/sched_pkg.sv
hw/instr_decode.sv
hw/reservation_station.sv
hw/alu_execute.sv
hw/result_regfile.sv
hw/issue_core_top.sv
testbench/tb_issue_core.sv

/* Bender.yml */
package:
  name: issue_core

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/sched_pkg.sv
      - hw/instr_decode.sv
      - hw/reservation_station.sv
      - hw/alu_execute.sv
      - hw/result_regfile.sv
      - hw/issue_core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_issue_core.sv
